//--- arcade_input.f
hw/arcade_input_pkg.sv
hw/host_io_pkg.sv
hw/ps2_key_decoder.sv
hw/dip_switch_store.sv
hw/arcade_input_mux.sv
hw/arcade_input_top.sv
tb/arcade_input_tb.sv

//--- hw/arcade_input_mux.sv
// Arcade control port combiner
`default_nettype none
`timescale 1ns/1ps

module arcade_input_mux (
    input  logic [arcade_input_pkg::KBD_BUTTONS-1:0] kbd_buttons,
    input  logic [arcade_input_pkg::JOY_W-1:0]       joystick_0,
    input  logic [arcade_input_pkg::JOY_W-1:0]       joystick_1,
    input  logic [15:0]                              dip_bytes,
    output logic [1:0]                               coin,
    output logic [1:0]                               start_buttons,
    output logic [3:0]                               p1_joystick,
    output logic [3:0]                               p2_joystick,
    output logic [3:0]                               p1_buttons,
    output logic [3:0]                               p2_buttons,
    output logic [15:0]                              dip_sw,
    output logic                                     pause_button
);

    import arcade_input_pkg::*;

    // Directions then buttons, both MSB first, active high
    function automatic logic [7:0] merge_player(
        input logic [KBD_BUTTONS-1:0] keys,
        input logic [JOY_W-1:0]       joy
    );
        merge_player = {
            keys[BTN_UP]    | joy[JOY_UP],
            keys[BTN_DOWN]  | joy[JOY_DOWN],
            keys[BTN_LEFT]  | joy[JOY_LEFT],
            keys[BTN_RIGHT] | joy[JOY_RIGHT],
            keys[BTN_A]     | joy[JOY_A],
            keys[BTN_B]     | joy[JOY_B],
            keys[BTN_X]     | joy[JOY_X],
            keys[BTN_Y]     | joy[JOY_Y]
        };
    endfunction

    logic [JOY_W-1:0] joy_any;
    logic [7:0]       p1_ctrl;
    logic [7:0]       p2_ctrl;

    // Shared controls listen to either pad
    assign joy_any = joystick_0 | joystick_1;

    ////////////////////////////////
    // Per-player controls
    ////////////////////////////////
    assign p1_ctrl = merge_player(kbd_buttons, joystick_0);
    assign p2_ctrl = merge_player(kbd_buttons, joystick_1);

    assign p1_joystick = ~p1_ctrl[7:4];
    assign p1_buttons  = ~p1_ctrl[3:0];
    assign p2_joystick = ~p2_ctrl[7:4];
    assign p2_buttons  = ~p2_ctrl[3:0];

    ////////////////////////////////
    // Shared controls
    ////////////////////////////////
    assign start_buttons = ~{kbd_buttons[BTN_START2] | joy_any[JOY_START2],
                             kbd_buttons[BTN_START1] | joy_any[JOY_START1]};

    // Coin 2 has no pad bit
    assign coin = ~{kbd_buttons[BTN_COIN2],
                    kbd_buttons[BTN_COIN1] | joy_any[JOY_COIN1]};

    assign pause_button = kbd_buttons[BTN_PAUSE] | joy_any[JOY_PAUSE];

    // Board reads switches active low
    assign dip_sw = ~dip_bytes;

endmodule

`default_nettype wire

//--- hw/arcade_input_pkg.sv
// Arcade player control definitions
`default_nettype none

package arcade_input_pkg;

    ////////////////////////////////
    // PS/2 set 2 scan codes
    ////////////////////////////////
    // Cursor keys arrive as extended codes, only the low byte is compared
    typedef enum logic [7:0] {
        KEY_1     = 8'h16,
        KEY_2     = 8'h1E,
        KEY_5     = 8'h2E,
        KEY_6     = 8'h36,
        KEY_P     = 8'h4D,
        KEY_UP    = 8'h75,
        KEY_DOWN  = 8'h72,
        KEY_LEFT  = 8'h6B,
        KEY_RIGHT = 8'h74,
        KEY_CTRL  = 8'h14,
        KEY_ALT   = 8'h11,
        KEY_SPACE = 8'h29,
        KEY_SHIFT = 8'h12
    } ps2_code_e;

    ////////////////////////////////
    // Held keyboard buttons
    ////////////////////////////////
    localparam int KBD_BUTTONS = 13;

    localparam int BTN_UP     = 0;
    localparam int BTN_DOWN   = 1;
    localparam int BTN_LEFT   = 2;
    localparam int BTN_RIGHT  = 3;
    localparam int BTN_A      = 4;
    localparam int BTN_B      = 5;
    localparam int BTN_X      = 6;
    localparam int BTN_Y      = 7;
    localparam int BTN_COIN1  = 8;
    localparam int BTN_COIN2  = 9;
    localparam int BTN_START1 = 10;
    localparam int BTN_START2 = 11;
    localparam int BTN_PAUSE  = 12;

    ////////////////////////////////
    // Host joystick word, 1 = pressed
    ////////////////////////////////
    localparam int JOY_W      = 16;

    localparam int JOY_RIGHT  = 0;
    localparam int JOY_LEFT   = 1;
    localparam int JOY_DOWN   = 2;
    localparam int JOY_UP     = 3;
    localparam int JOY_A      = 4;
    localparam int JOY_B      = 5;
    localparam int JOY_X      = 6;
    localparam int JOY_Y      = 7;
    localparam int JOY_START1 = 8;
    localparam int JOY_COIN1  = 9;
    localparam int JOY_START2 = 10;
    localparam int JOY_PAUSE  = 11;

endpackage

`default_nettype wire

//--- hw/arcade_input_top.sv
// Arcade input front end
`default_nettype none
`timescale 1ns/1ps

module arcade_input_top (
    input  logic                                  CLK_32M,
    input  logic                                  reset,
    input  logic [host_io_pkg::PS2_W-1:0]         ps2_key,
    input  logic [arcade_input_pkg::JOY_W-1:0]    joystick_0,
    input  logic [arcade_input_pkg::JOY_W-1:0]    joystick_1,
    input  logic                                  ioctl_wr,
    input  logic [host_io_pkg::IOCTL_INDEX_W-1:0] ioctl_index,
    input  logic [host_io_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
    input  logic [host_io_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
    output logic [1:0]                            coin,
    output logic [1:0]                            start_buttons,
    output logic [3:0]                            p1_joystick,
    output logic [3:0]                            p2_joystick,
    output logic [3:0]                            p1_buttons,
    output logic [3:0]                            p2_buttons,
    output logic [15:0]                           dip_sw,
    output logic                                  pause_button
);

    import arcade_input_pkg::*;
    import host_io_pkg::*;

    logic [KBD_BUTTONS-1:0] kbd_buttons;
    logic [8*DIP_BYTES-1:0] dip_bytes;

    ps2_key_decoder u_ps2_key_decoder (
        .CLK_32M     (CLK_32M),
        .reset       (reset),
        .ps2_key     (ps2_key),
        .kbd_buttons (kbd_buttons)
    );

    dip_switch_store u_dip_switch_store (
        .CLK_32M     (CLK_32M),
        .reset       (reset),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .dip_bytes   (dip_bytes)
    );

    // Combinational path to the board ports
    arcade_input_mux u_arcade_input_mux (
        .kbd_buttons   (kbd_buttons),
        .joystick_0    (joystick_0),
        .joystick_1    (joystick_1),
        .dip_bytes     (dip_bytes),
        .coin          (coin),
        .start_buttons (start_buttons),
        .p1_joystick   (p1_joystick),
        .p2_joystick   (p2_joystick),
        .p1_buttons    (p1_buttons),
        .p2_buttons    (p2_buttons),
        .dip_sw        (dip_sw),
        .pause_button  (pause_button)
    );

endmodule

`default_nettype wire

//--- hw/dip_switch_store.sv
// DIP switch byte store
`default_nettype none
`timescale 1ns/1ps

module dip_switch_store (
    input  logic                                  CLK_32M,
    input  logic                                  reset,
    input  logic                                  ioctl_wr,
    input  logic [host_io_pkg::IOCTL_INDEX_W-1:0] ioctl_index,
    input  logic [host_io_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
    input  logic [host_io_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
    output logic [8*host_io_pkg::DIP_BYTES-1:0]   dip_bytes
);

    import host_io_pkg::*;

    logic dip_write;

    // Strobe to the DIP index, inside the kept byte range
    assign dip_write = ioctl_wr
                    && (ioctl_index == DIP_INDEX)
                    && (ioctl_addr < IOCTL_ADDR_W'(DIP_BYTES));

    ////////////////////////////////
    // Byte capture
    ////////////////////////////////
    always_ff @(posedge CLK_32M) begin
        if (reset) begin
            dip_bytes <= '0;
        end else if (dip_write) begin
            // Address bit 0 picks the byte lane
            dip_bytes[IOCTL_DATA_W*ioctl_addr[0] +: IOCTL_DATA_W] <= ioctl_dout;
        end
    end

    ////////////////////////////////
    // Checks
    ////////////////////////////////
    a_dip_hold: assert property (
        @(posedge CLK_32M) disable iff (reset)
        !dip_write |=> $stable(dip_bytes)
    ) else $error("DIP bytes changed without a DIP write");

endmodule

`default_nettype wire

//--- hw/host_io_pkg.sv
// Host link definitions
`default_nettype none

package host_io_pkg;

    ////////////////////////////////
    // PS/2 event word
    ////////////////////////////////
    // Bit 10 toggles on every event, bit 9 is set on make
    localparam int PS2_W       = 11;
    localparam int PS2_TOGGLE  = 10;
    localparam int PS2_PRESSED = 9;
    // Scan code in the low byte
    localparam int PS2_CODE_W  = 8;

    ////////////////////////////////
    // Download port
    ////////////////////////////////
    localparam int IOCTL_ADDR_W  = 25;
    localparam int IOCTL_DATA_W  = 8;
    localparam int IOCTL_INDEX_W = 8;

    // Index used by the host for the DIP switch block
    localparam logic [IOCTL_INDEX_W-1:0] DIP_INDEX = 8'd254;

    // Only the first two DIP bytes are read by the board
    localparam int DIP_BYTES = 2;

endpackage

`default_nettype wire

//--- hw/ps2_key_decoder.sv
// PS/2 key event decoder
`default_nettype none
`timescale 1ns/1ps

module ps2_key_decoder (
    input  logic                                   CLK_32M,
    input  logic                                   reset,
    input  logic [host_io_pkg::PS2_W-1:0]          ps2_key,
    output logic [arcade_input_pkg::KBD_BUTTONS-1:0] kbd_buttons
);

    import arcade_input_pkg::*;
    import host_io_pkg::*;

    logic      last_toggle;
    logic      new_event;
    logic      pressed;
    ps2_code_e key_code;

    // Host flips the toggle bit once per key event
    assign new_event = ps2_key[PS2_TOGGLE] != last_toggle;
    assign pressed   = ps2_key[PS2_PRESSED];
    assign key_code  = ps2_code_e'(ps2_key[PS2_CODE_W-1:0]);

    ////////////////////////////////
    // Held key state
    ////////////////////////////////
    always_ff @(posedge CLK_32M) begin
        if (reset) begin
            last_toggle <= 1'b0;
            kbd_buttons <= '0;
        end else if (new_event) begin
            last_toggle <= ps2_key[PS2_TOGGLE];
            case (key_code)
                KEY_1:     kbd_buttons[BTN_START1] <= pressed;
                KEY_2:     kbd_buttons[BTN_START2] <= pressed;
                KEY_5:     kbd_buttons[BTN_COIN1]  <= pressed;
                KEY_6:     kbd_buttons[BTN_COIN2]  <= pressed;
                KEY_P:     kbd_buttons[BTN_PAUSE]  <= pressed;
                KEY_UP:    kbd_buttons[BTN_UP]     <= pressed;
                KEY_DOWN:  kbd_buttons[BTN_DOWN]   <= pressed;
                KEY_LEFT:  kbd_buttons[BTN_LEFT]   <= pressed;
                KEY_RIGHT: kbd_buttons[BTN_RIGHT]  <= pressed;
                KEY_CTRL:  kbd_buttons[BTN_A]      <= pressed;
                KEY_ALT:   kbd_buttons[BTN_B]      <= pressed;
                KEY_SPACE: kbd_buttons[BTN_X]      <= pressed;
                KEY_SHIFT: kbd_buttons[BTN_Y]      <= pressed;
                // Other codes only consume the toggle
                default: ;
            endcase
        end
    end

    ////////////////////////////////
    // Checks
    ////////////////////////////////
    // All keys released once reset has been seen
    a_reset_release: assert property (
        @(posedge CLK_32M) reset |=> kbd_buttons == '0
    ) else $error("keys still held after reset");

    // Buttons only move on a fresh toggle
    a_no_event_stable: assert property (
        @(posedge CLK_32M) disable iff (reset)
        !new_event |=> $stable(kbd_buttons)
    ) else $error("key state changed without a PS/2 event");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the arcade input testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f arcade_input.f --top-module arcade_input_tb -o sim_arcade_input

# The log decides the result, so a fatal stop must not end the script here
./obj_dir/sim_arcade_input > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- tb/arcade_input_tb.sv
// Arcade input front end testbench
`default_nettype none
`timescale 1ns/1ps

module arcade_input_tb;

    import arcade_input_pkg::*;
    import host_io_pkg::*;

    logic                     CLK_32M;
    logic                     reset;
    logic [PS2_W-1:0]         ps2_key;
    logic [JOY_W-1:0]         joystick_0;
    logic [JOY_W-1:0]         joystick_1;
    logic                     ioctl_wr;
    logic [IOCTL_INDEX_W-1:0] ioctl_index;
    logic [IOCTL_ADDR_W-1:0]  ioctl_addr;
    logic [IOCTL_DATA_W-1:0]  ioctl_dout;
    logic [1:0]               coin;
    logic [1:0]               start_buttons;
    logic [3:0]               p1_joystick;
    logic [3:0]               p2_joystick;
    logic [3:0]               p1_buttons;
    logic [3:0]               p2_buttons;
    logic [15:0]              dip_sw;
    logic                     pause_button;

    // Thirteen mapped codes, then three the core ignores
    localparam logic [7:0] SCAN_CODES [16] = '{
        KEY_1, KEY_2, KEY_5, KEY_6, KEY_P, KEY_UP, KEY_DOWN, KEY_LEFT,
        KEY_RIGHT, KEY_CTRL, KEY_ALT, KEY_SPACE, KEY_SHIFT, 8'h1C, 8'h00, 8'hF0
    };

    logic [KBD_BUTTONS-1:0] model_keys;
    logic                   model_toggle;
    logic [15:0]            model_dip;
    int                     write_count;
    logic [31:0]            lfsr_state = 32'h7aa2;
    string                  test_name = "reset";

    logic [JOY_W-1:0] jboth;
    logic [1:0]       exp_coin;
    logic [1:0]       exp_start;
    logic [3:0]       exp_p1_dir;
    logic [3:0]       exp_p2_dir;
    logic [3:0]       exp_p1_btn;
    logic [3:0]       exp_p2_btn;
    logic [15:0]      exp_dip;
    logic             exp_pause;

    arcade_input_top dut (.*);

    initial begin
        CLK_32M = 1'b0;
        forever #10 CLK_32M = ~CLK_32M;
    end

    ////////////////////////////////
    // Helpers
    ////////////////////////////////
    // Fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        random_bits = value;
    endfunction

    // One-hot button for a scan code or zero when unmapped
    function automatic logic [KBD_BUTTONS-1:0] key_mask(input logic [7:0] code);
        logic [KBD_BUTTONS-1:0] one;
        one = KBD_BUTTONS'(1);
        case (code)
            KEY_1:     key_mask = one << BTN_START1;
            KEY_2:     key_mask = one << BTN_START2;
            KEY_5:     key_mask = one << BTN_COIN1;
            KEY_6:     key_mask = one << BTN_COIN2;
            KEY_P:     key_mask = one << BTN_PAUSE;
            KEY_UP:    key_mask = one << BTN_UP;
            KEY_DOWN:  key_mask = one << BTN_DOWN;
            KEY_LEFT:  key_mask = one << BTN_LEFT;
            KEY_RIGHT: key_mask = one << BTN_RIGHT;
            KEY_CTRL:  key_mask = one << BTN_A;
            KEY_ALT:   key_mask = one << BTN_B;
            KEY_SPACE: key_mask = one << BTN_X;
            KEY_SHIFT: key_mask = one << BTN_Y;
            default:   key_mask = '0;
        endcase
    endfunction

    // Directions up, down, left, right from MSB
    function automatic logic [3:0] dirs_of(input logic [JOY_W-1:0] joy);
        dirs_of = {joy[JOY_UP], joy[JOY_DOWN], joy[JOY_LEFT], joy[JOY_RIGHT]};
    endfunction

    function automatic logic [3:0] buttons_of(input logic [JOY_W-1:0] joy);
        buttons_of = {joy[JOY_A], joy[JOY_B], joy[JOY_X], joy[JOY_Y]};
    endfunction

    task automatic report_mismatch(input string port, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("Mismatch in test %s on %s: expected %h, actual %h",
                 test_name, port, expected, actual);
        $display("Errors found");
        $fatal(1, "output check failed");
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge CLK_32M);
    endtask

    // Waits until the model has consumed the given toggle value
    task automatic wait_key_taken(input logic toggle);
        int cycles;
        cycles = 0;
        while (model_toggle !== toggle) begin
            if (cycles == 8) begin
                $display("Timeout: PS/2 event was not taken within 8 cycles");
                $display("Errors found");
                $fatal(1, "key wait timed out");
            end else begin
                @(negedge CLK_32M);
                cycles++;
            end
        end
    endtask

    task automatic send_key(input logic [7:0] code, input logic pressed);
        ps2_key = {~ps2_key[PS2_TOGGLE], pressed, 1'b0, code};
        wait_key_taken(ps2_key[PS2_TOGGLE]);
    endtask

    task automatic download(input logic [7:0] index, input int addr,
                            input logic [7:0] data, input logic strobe);
        int target;
        int cycles;
        target      = write_count + 1;
        cycles      = 0;
        ioctl_index = index;
        ioctl_addr  = IOCTL_ADDR_W'(addr);
        ioctl_dout  = data;
        ioctl_wr    = strobe;
        @(negedge CLK_32M);
        ioctl_wr = 1'b0;
        while (strobe && write_count < target) begin
            if (cycles == 8) begin
                $display("Timeout: download write was not seen within 8 cycles");
                $display("Errors found");
                $fatal(1, "write wait timed out");
            end else begin
                @(negedge CLK_32M);
                cycles++;
            end
        end
        idle(1);
    endtask

    ////////////////////////////////
    // Reference model
    ////////////////////////////////
    always @(posedge CLK_32M) begin : model_update
        logic [KBD_BUTTONS-1:0] mask;
        mask = key_mask(ps2_key[PS2_CODE_W-1:0]);
        if (reset) begin
            model_keys   <= '0;
            model_toggle <= 1'b0;
            model_dip    <= '0;
            write_count  <= 0;
        end else begin
            if (ps2_key[PS2_TOGGLE] != model_toggle) begin
                model_toggle <= ps2_key[PS2_TOGGLE];
                model_keys   <= ps2_key[PS2_PRESSED] ? (model_keys | mask)
                                                     : (model_keys & ~mask);
            end
            if (ioctl_wr) begin
                write_count <= write_count + 1;
                if (ioctl_index == DIP_INDEX && ioctl_addr < IOCTL_ADDR_W'(DIP_BYTES)) begin
                    if (ioctl_addr[0])
                        model_dip[15:8] <= ioctl_dout;
                    else
                        model_dip[7:0] <= ioctl_dout;
                end
            end
        end
    end

    always_comb begin
        jboth      = joystick_0 | joystick_1;
        exp_p1_dir = ~(dirs_of(joystick_0) | {model_keys[BTN_UP], model_keys[BTN_DOWN],
                                               model_keys[BTN_LEFT], model_keys[BTN_RIGHT]});
        exp_p2_dir = ~(dirs_of(joystick_1) | {model_keys[BTN_UP], model_keys[BTN_DOWN],
                                               model_keys[BTN_LEFT], model_keys[BTN_RIGHT]});
        exp_p1_btn = ~(buttons_of(joystick_0) | {model_keys[BTN_A], model_keys[BTN_B],
                                                  model_keys[BTN_X], model_keys[BTN_Y]});
        exp_p2_btn = ~(buttons_of(joystick_1) | {model_keys[BTN_A], model_keys[BTN_B],
                                                  model_keys[BTN_X], model_keys[BTN_Y]});
        exp_start  = ~{model_keys[BTN_START2] | jboth[JOY_START2],
                       model_keys[BTN_START1] | jboth[JOY_START1]};
        exp_coin   = ~{model_keys[BTN_COIN2], model_keys[BTN_COIN1] | jboth[JOY_COIN1]};
        exp_pause  = model_keys[BTN_PAUSE] | jboth[JOY_PAUSE];
        exp_dip    = ~model_dip;
    end

    ////////////////////////////////
    // Output checks
    ////////////////////////////////
    a_coin: assert property (@(posedge CLK_32M) disable iff (reset) coin == exp_coin)
        else report_mismatch("coin", 16'($sampled(exp_coin)), 16'($sampled(coin)));
    a_start: assert property (@(posedge CLK_32M) disable iff (reset) start_buttons == exp_start)
        else report_mismatch("start", 16'($sampled(exp_start)), 16'($sampled(start_buttons)));
    a_p1_dir: assert property (@(posedge CLK_32M) disable iff (reset) p1_joystick == exp_p1_dir)
        else report_mismatch("p1_joystick", 16'($sampled(exp_p1_dir)),
                             16'($sampled(p1_joystick)));
    a_p2_dir: assert property (@(posedge CLK_32M) disable iff (reset) p2_joystick == exp_p2_dir)
        else report_mismatch("p2_joystick", 16'($sampled(exp_p2_dir)),
                             16'($sampled(p2_joystick)));
    a_p1_btn: assert property (@(posedge CLK_32M) disable iff (reset) p1_buttons == exp_p1_btn)
        else report_mismatch("p1_buttons", 16'($sampled(exp_p1_btn)), 16'($sampled(p1_buttons)));
    a_p2_btn: assert property (@(posedge CLK_32M) disable iff (reset) p2_buttons == exp_p2_btn)
        else report_mismatch("p2_buttons", 16'($sampled(exp_p2_btn)), 16'($sampled(p2_buttons)));
    a_dip: assert property (@(posedge CLK_32M) disable iff (reset) dip_sw == exp_dip)
        else report_mismatch("dip_sw", $sampled(exp_dip), $sampled(dip_sw));
    a_pause: assert property (@(posedge CLK_32M) disable iff (reset) pause_button == exp_pause)
        else report_mismatch("pause", 16'($sampled(exp_pause)), 16'($sampled(pause_button)));

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////
    initial begin
        logic [31:0] word;
        reset       = 1'b1;
        ps2_key     = '0;
        joystick_0  = '0;
        joystick_1  = '0;
        ioctl_wr    = 1'b0;
        ioctl_index = '0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        idle(2);
        reset = 1'b0;
        idle(3);

        test_name = "keyboard";
        for (int k = 0; k < 16; k++) begin
            send_key(SCAN_CODES[k], 1'b1);
            idle(1);
            // Same toggle again must be ignored
            ps2_key[PS2_PRESSED] = 1'b0;
            idle(2);
            send_key(SCAN_CODES[k], 1'b0);
            idle(1);
        end

        test_name = "joystick";
        for (int b = 0; b < 12; b++) begin
            joystick_0 = JOY_W'(1) << b;
            idle(1);
            joystick_0 = '0;
            joystick_1 = JOY_W'(1) << b;
            idle(1);
            joystick_1 = '0;
        end

        test_name = "dip";
        download(DIP_INDEX, 0, 8'hA5, 1'b1);
        download(DIP_INDEX, 1, 8'h3C, 1'b1);
        download(8'd253, 0, 8'hFF, 1'b1);
        download(DIP_INDEX, 2, 8'h11, 1'b1);
        download(DIP_INDEX, 3, 8'h22, 1'b1);
        download(DIP_INDEX, 0, 8'h00, 1'b0);

        test_name = "random";
        for (int n = 0; n < 400; n++) begin
            word       = random_bits(16);
            joystick_0 = word[15:0];
            word       = random_bits(16);
            joystick_1 = word[15:0];
            word       = random_bits(6);
            if (word[5])
                ps2_key = {~ps2_key[PS2_TOGGLE], word[4], 1'b0, SCAN_CODES[word[3:0]]};
            word        = random_bits(12);
            ioctl_wr    = word[11];
            ioctl_index = word[10] ? DIP_INDEX : 8'd253;
            ioctl_addr  = IOCTL_ADDR_W'(word[9:8]);
            ioctl_dout  = word[7:0];
            @(negedge CLK_32M);
        end
        ioctl_wr = 1'b0;
        idle(3);

        // Reset while a key is held and the DIP bytes are set
        test_name  = "reset_held";
        joystick_0 = '0;
        joystick_1 = '0;
        send_key(KEY_P, 1'b1);
        download(DIP_INDEX, 1, 8'h5A, 1'b1);
        reset   = 1'b1;
        ps2_key = '0;
        idle(2);
        reset = 1'b0;
        idle(3);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
